/* all.f */
+incdir+rtl
rtl/sd_bus_pkg.sv
rtl/sd_host_pkg.sv
rtl/cmd_xfer_if.sv
rtl/sd_crc7.sv
rtl/cmd_master.sv
rtl/cmd_physical.sv
rtl/sd_cmd.sv
sim/sd_cmd_assert.sv
sim/sd_cmd_tb.sv

/* rtl/cmd_master.sv */
`default_nettype none
`include "sd_cmd_defs.svh"

module cmd_master (
	input  logic        clk_host,
	input  logic        rst_n,
	input  logic        new_cmd,
	input  logic [5:0]  cmd_index,
	input  logic [31:0] cmd_arg,
	cmd_xfer_if.master  xfer,
	output logic        cmd_busy,
	output logic        cmd_complete,
	output logic        timeout_error,
	output logic        crc_error,
	output logic        index_error,
	output logic [31:0] response_status
);

	sd_host_pkg::master_state_e state;
	sd_host_pkg::cmd_result_e   result;
	logic [`SD_SYNC_STAGES-1:0] ack_sync;
	logic [`SD_SYNC_STAGES-1:0] idle_sync;
	logic                       ack_seen;
	logic                       phys_ready;
	logic                       accept;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Synchronizers from the SD clock domain.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_host or negedge rst_n) begin
		if (!rst_n) begin
			ack_sync  <= '0;
			idle_sync <= '0;
		end else begin
			ack_sync  <= {ack_sync[`SD_SYNC_STAGES-2:0], xfer.ack};
			idle_sync <= {idle_sync[`SD_SYNC_STAGES-2:0], xfer.phys_idle};
		end
	end

	assign ack_seen   = ack_sync[`SD_SYNC_STAGES-1];
	assign phys_ready = idle_sync[`SD_SYNC_STAGES-1] && !ack_seen;

	// Busy is low only in idle and wait_release.
	assign accept = new_cmd && !cmd_busy;

	always_ff @(posedge clk_host) begin
		if (accept) begin
			xfer.cmd <= '{index: cmd_index, arg: cmd_arg};
		end
	end

	// CRC result arrives folded into the end bit.
	always_comb begin
		if (xfer.timed_out)
			result = sd_host_pkg::res_timeout;
		else if (!xfer.resp.end_bit)
			result = sd_host_pkg::res_crc;
		else if (xfer.resp.index != xfer.cmd.index)
			result = sd_host_pkg::res_index;
		else
			result = sd_host_pkg::res_ok;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Request side of the handshake.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_host or negedge rst_n) begin
		if (!rst_n) begin
			state           <= sd_host_pkg::ms_idle;
			xfer.req        <= 1'b0;
			cmd_busy        <= 1'b0;
			cmd_complete    <= 1'b0;
			timeout_error   <= 1'b0;
			crc_error       <= 1'b0;
			index_error     <= 1'b0;
			response_status <= 32'd0;
		end else begin
			cmd_complete  <= 1'b0;
			timeout_error <= 1'b0;
			crc_error     <= 1'b0;
			index_error   <= 1'b0;
			case (state)
				sd_host_pkg::ms_idle: begin
					if (accept) begin
						cmd_busy <= 1'b1;
						state    <= sd_host_pkg::ms_request;
					end
				end
				sd_host_pkg::ms_request: begin
					if (phys_ready) begin
						xfer.req <= 1'b1;
						state    <= sd_host_pkg::ms_wait_ack;
					end
				end
				sd_host_pkg::ms_wait_ack: begin
					if (ack_seen) begin
						xfer.req <= 1'b0;
						cmd_busy <= 1'b0;
						case (result)
							sd_host_pkg::res_ok:      cmd_complete  <= 1'b1;
							sd_host_pkg::res_timeout: timeout_error <= 1'b1;
							sd_host_pkg::res_crc:     crc_error     <= 1'b1;
							default:                  index_error   <= 1'b1;
						endcase
						// Status kept from the last card answer.
						if (result != sd_host_pkg::res_timeout)
							response_status <= xfer.resp.status;
						state <= sd_host_pkg::ms_wait_release;
					end
				end
				default: begin
					if (accept) begin
						cmd_busy <= 1'b1;
						state    <= sd_host_pkg::ms_request;
					end else if (!ack_seen) begin
						state <= sd_host_pkg::ms_idle;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* rtl/cmd_physical.sv */
`default_nettype none
`include "sd_cmd_defs.svh"

module cmd_physical (
	input  logic         clk_sd_card,
	input  logic         rst_n,
	cmd_xfer_if.physical xfer,
	input  logic         cmd_from_sd,
	output logic         cmd_to_sd,
	output logic         cmd_to_sd_oe
);

	localparam int unsigned TOP     = `SD_TOKEN_BITS - 1;
	localparam int unsigned CRC_END = `SD_TOKEN_BITS - 8;
	localparam int unsigned CNT_W   = $clog2(`SD_TOKEN_BITS);
	localparam int unsigned TMO_W   = $clog2(`SD_RESP_TIMEOUT);

	sd_bus_pkg::phys_state_e    state;
	sd_bus_pkg::sd_token_t      tx_sr;
	logic [TOP-1:0]             rx_sr;
	logic [`SD_SYNC_STAGES-1:0] req_sync;
	logic                       req_seen;
	logic [CNT_W-1:0]           bit_cnt;
	logic [TMO_W-1:0]           tmo_cnt;
	logic                       tx_bit;
	logic                       crc_clear;
	logic                       crc_shift;
	logic                       crc_in;
	logic [6:0]                 crc;
	logic                       crc_ok;

	sd_crc7 crc0 (
		.clk_sd_card (clk_sd_card),
		.rst_n       (rst_n),
		.clear       (crc_clear),
		.shift       (crc_shift),
		.bit_in      (crc_in),
		.crc         (crc)
	);

	assign req_seen = req_sync[`SD_SYNC_STAGES-1];

	// CRC goes out straight from the generator on bit 40.
	assign tx_bit    = (bit_cnt == CNT_W'(CRC_END)) ? crc[6] : tx_sr[TOP];
	assign cmd_to_sd = cmd_to_sd_oe ? tx_bit : 1'b1;

	// Received CRC sits in the last seven bits shifted in.
	assign crc_ok = (rx_sr[6:0] == crc);

	always_comb begin
		crc_clear = 1'b0;
		crc_shift = 1'b0;
		crc_in    = 1'b0;
		case (state)
			sd_bus_pkg::ph_idle: begin
				crc_clear = 1'b1;
			end
			sd_bus_pkg::ph_send: begin
				crc_shift = (bit_cnt < CNT_W'(CRC_END));
				crc_in    = tx_sr[TOP];
				crc_clear = (bit_cnt == CNT_W'(TOP));
			end
			sd_bus_pkg::ph_wait_resp: begin
				crc_shift = !cmd_from_sd;
				crc_in    = cmd_from_sd;
			end
			sd_bus_pkg::ph_recv: begin
				crc_shift = (bit_cnt < CNT_W'(CRC_END));
				crc_in    = cmd_from_sd;
			end
			default: begin
				crc_clear = 1'b0;
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Token FSM.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_sd_card or negedge rst_n) begin
		if (!rst_n) begin
			req_sync       <= '0;
			state          <= sd_bus_pkg::ph_idle;
			cmd_to_sd_oe   <= 1'b0;
			bit_cnt        <= '0;
			tmo_cnt        <= '0;
			xfer.ack       <= 1'b0;
			xfer.timed_out <= 1'b0;
			xfer.phys_idle <= 1'b1;
		end else begin
			req_sync <= {req_sync[`SD_SYNC_STAGES-2:0], xfer.req};
			case (state)
				sd_bus_pkg::ph_idle: begin
					if (req_seen) begin
						cmd_to_sd_oe   <= 1'b1;
						bit_cnt        <= '0;
						xfer.phys_idle <= 1'b0;
						state          <= sd_bus_pkg::ph_send;
					end
				end
				sd_bus_pkg::ph_send: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == CNT_W'(TOP)) begin
						cmd_to_sd_oe <= 1'b0;
						tmo_cnt      <= '0;
						state        <= sd_bus_pkg::ph_wait_resp;
					end
				end
				sd_bus_pkg::ph_wait_resp: begin
					if (!cmd_from_sd) begin
						bit_cnt <= CNT_W'(1);
						state   <= sd_bus_pkg::ph_recv;
					end else if (tmo_cnt == TMO_W'(`SD_RESP_TIMEOUT - 1)) begin
						xfer.timed_out <= 1'b1;
						state          <= sd_bus_pkg::ph_report;
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
				end
				sd_bus_pkg::ph_recv: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == CNT_W'(TOP)) begin
						xfer.timed_out <= 1'b0;
						state          <= sd_bus_pkg::ph_report;
					end
				end
				sd_bus_pkg::ph_report: begin
					xfer.ack <= 1'b1;
					state    <= sd_bus_pkg::ph_release;
				end
				sd_bus_pkg::ph_release: begin
					if (!req_seen) begin
						xfer.ack       <= 1'b0;
						xfer.phys_idle <= 1'b1;
						state          <= sd_bus_pkg::ph_idle;
					end
				end
				default: begin
					state <= sd_bus_pkg::ph_idle;
				end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Shift registers and response capture.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk_sd_card) begin
		case (state)
			sd_bus_pkg::ph_idle: begin
				tx_sr <= {1'b0, 1'b1, xfer.cmd.index, xfer.cmd.arg, 7'd0, 1'b1};
			end
			sd_bus_pkg::ph_send: begin
				if (bit_cnt == CNT_W'(CRC_END))
					tx_sr <= {crc[5:0], 1'b1, {(`SD_TOKEN_BITS - 7){1'b0}}};
				else
					tx_sr <= tx_sr << 1;
			end
			sd_bus_pkg::ph_wait_resp: begin
				rx_sr <= {rx_sr[TOP-2:0], cmd_from_sd};
			end
			sd_bus_pkg::ph_recv: begin
				rx_sr <= {rx_sr[TOP-2:0], cmd_from_sd};
				// Bad CRC shows up as a zero end bit.
				if (bit_cnt == CNT_W'(TOP))
					xfer.resp <= sd_bus_pkg::sd_resp_t'({rx_sr, cmd_from_sd & crc_ok});
			end
			default: begin
				rx_sr <= rx_sr;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/cmd_xfer_if.sv */
`default_nettype none

// Four-phase handshake between the host and SD clock domains.
interface cmd_xfer_if;

	logic                 req;
	sd_bus_pkg::sd_cmd_t  cmd;
	logic                 ack;
	sd_bus_pkg::sd_resp_t resp;
	logic                 timed_out;
	logic                 phys_idle;

	modport master (
		output req,
		output cmd,
		input  ack,
		input  resp,
		input  timed_out,
		input  phys_idle
	);

	modport physical (
		input  req,
		input  cmd,
		output ack,
		output resp,
		output timed_out,
		output phys_idle
	);

endinterface

`default_nettype wire

/* rtl/sd_bus_pkg.sv */
`default_nettype none
`include "sd_cmd_defs.svh"

package sd_bus_pkg;

	// Index and argument as handed to the card side.
	typedef struct packed {
		logic [5:0]  index;
		logic [31:0] arg;
	} sd_cmd_t;

	// R1 style response as it arrives MSB first.
	typedef struct packed {
		logic        start_bit;
		logic        tx_bit;
		logic [5:0]  index;
		logic [31:0] status;
		logic [6:0]  crc;
		logic        end_bit;
	} sd_resp_t;

	typedef logic [`SD_TOKEN_BITS-1:0] sd_token_t;

	typedef enum logic [2:0] {
		ph_idle,
		ph_send,
		ph_wait_resp,
		ph_recv,
		ph_report,
		ph_release
	} phys_state_e;

endpackage

`default_nettype wire

/* rtl/sd_cmd.sv */
`default_nettype none

module sd_cmd (
	input  logic        clk_host,
	input  logic        rst_n,
	input  logic        new_cmd,
	input  logic [5:0]  cmd_index,
	input  logic [31:0] cmd_arg,
	input  logic        clk_sd_card,
	input  logic        cmd_from_sd,
	output logic        cmd_busy,
	output logic        cmd_complete,
	output logic        timeout_error,
	output logic        crc_error,
	output logic        index_error,
	output logic [31:0] response_status,
	output logic        cmd_to_sd,
	output logic        cmd_to_sd_oe
);

	cmd_xfer_if xfer ();

	// Host clock domain.
	cmd_master master0 (
		.clk_host        (clk_host),
		.rst_n           (rst_n),
		.new_cmd         (new_cmd),
		.cmd_index       (cmd_index),
		.cmd_arg         (cmd_arg),
		.xfer            (xfer.master),
		.cmd_busy        (cmd_busy),
		.cmd_complete    (cmd_complete),
		.timeout_error   (timeout_error),
		.crc_error       (crc_error),
		.index_error     (index_error),
		.response_status (response_status)
	);

	// SD card clock domain.
	cmd_physical physical0 (
		.clk_sd_card  (clk_sd_card),
		.rst_n        (rst_n),
		.xfer         (xfer.physical),
		.cmd_from_sd  (cmd_from_sd),
		.cmd_to_sd    (cmd_to_sd),
		.cmd_to_sd_oe (cmd_to_sd_oe)
	);

endmodule

`default_nettype wire

/* rtl/sd_cmd_defs.svh */
`ifndef SD_CMD_DEFS_SVH
`define SD_CMD_DEFS_SVH

// Command and response token length in bits.
`define SD_TOKEN_BITS 48

// NCR limit in SD clocks after the command end bit.
`define SD_RESP_TIMEOUT 64

// Flops per req/ack synchronizer.
`define SD_SYNC_STAGES 2

`endif

/* rtl/sd_crc7.sv */
`default_nettype none

module sd_crc7 (
	input  logic       clk_sd_card,
	input  logic       rst_n,
	input  logic       clear,
	input  logic       shift,
	input  logic       bit_in,
	output logic [6:0] crc
);

	logic feedback;

	// Polynomial x^7 + x^3 + 1 with the MSB out first.
	assign feedback = bit_in ^ crc[6];

	always_ff @(posedge clk_sd_card or negedge rst_n) begin
		if (!rst_n) begin
			crc <= 7'd0;
		end else if (clear) begin
			crc <= 7'd0;
		end else if (shift) begin
			crc <= {crc[5:0], 1'b0} ^ {3'b000, feedback, 2'b00, feedback};
		end
	end

endmodule

`default_nettype wire

/* rtl/sd_host_pkg.sv */
`default_nettype none

package sd_host_pkg;

	// Outcome of one command.
	typedef enum logic [1:0] {
		res_ok,
		res_timeout,
		res_crc,
		res_index
	} cmd_result_e;

	typedef enum logic [1:0] {
		ms_idle,
		ms_request,
		ms_wait_ack,
		ms_wait_release
	} master_state_e;

endpackage

`default_nettype wire

/* sim/sd_cmd_assert.sv */
`default_nettype none

module sd_cmd_assert (
	input logic clk_host,
	input logic clk_sd_card,
	input logic rst_n,
	input logic cmd_busy,
	input logic cmd_complete,
	input logic timeout_error,
	input logic crc_error,
	input logic index_error,
	input logic cmd_to_sd,
	input logic cmd_to_sd_oe
);

	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0;

	// Released line idles high.
	line_idle_high: assert property (@(posedge clk_sd_card) disable iff (!rst_n)
		!cmd_to_sd_oe |-> cmd_to_sd)
		else begin
			$error("cmd_to_sd is low while cmd_to_sd_oe is low");
			fail_count++;
		end

	one_flag: assert property (@(posedge clk_host) disable iff (!rst_n)
		$onehot0({cmd_complete, timeout_error, crc_error, index_error}))
		else begin
			$error("more than one completion flag is high");
			fail_count++;
		end

	oe_while_busy: assert property (@(posedge clk_sd_card) disable iff (!rst_n)
		cmd_to_sd_oe |-> cmd_busy)
		else begin
			$error("cmd_to_sd_oe is high while cmd_busy is low");
			fail_count++;
		end

	// Flag and busy fall share one host edge.
	flag_ends_busy: assert property (@(posedge clk_host) disable iff (!rst_n)
		(cmd_complete || timeout_error || crc_error || index_error) |-> $fell(cmd_busy))
		else begin
			$error("completion flag without a falling cmd_busy");
			fail_count++;
		end

endmodule

bind sd_cmd sd_cmd_assert assert0 (
	.clk_host      (clk_host),
	.clk_sd_card   (clk_sd_card),
	.rst_n         (rst_n),
	.cmd_busy      (cmd_busy),
	.cmd_complete  (cmd_complete),
	.timeout_error (timeout_error),
	.crc_error     (crc_error),
	.index_error   (index_error),
	.cmd_to_sd     (cmd_to_sd),
	.cmd_to_sd_oe  (cmd_to_sd_oe)
);

`default_nettype wire

/* sim/sd_cmd_tb.sv */
`default_nettype none

module sd_cmd_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int HOST_HALF   = 50;
	localparam int SD_HALF     = 130;
	localparam int DRIVE_DELAY = 5;
	localparam int OE_LIMIT    = 400;
	localparam int FLAG_LIMIT  = 2000;

	typedef enum int {
		resp_good,
		resp_none,
		resp_bad_crc,
		resp_bad_index
	} resp_mode_e;

	logic        clk_host;
	logic        clk_sd_card;
	logic        rst_n;
	logic        new_cmd;
	logic [5:0]  cmd_index;
	logic [31:0] cmd_arg;
	logic        cmd_from_sd;
	logic        cmd_busy;
	logic        cmd_complete;
	logic        timeout_error;
	logic        crc_error;
	logic        index_error;
	logic [31:0] response_status;
	logic        cmd_to_sd;
	logic        cmd_to_sd_oe;

	integer      seed = 61;
	string       test_name;
	logic [31:0] last_status;

	sd_cmd dut0 (
		.clk_host        (clk_host),
		.rst_n           (rst_n),
		.new_cmd         (new_cmd),
		.cmd_index       (cmd_index),
		.cmd_arg         (cmd_arg),
		.clk_sd_card     (clk_sd_card),
		.cmd_from_sd     (cmd_from_sd),
		.cmd_busy        (cmd_busy),
		.cmd_complete    (cmd_complete),
		.timeout_error   (timeout_error),
		.crc_error       (crc_error),
		.index_error     (index_error),
		.response_status (response_status),
		.cmd_to_sd       (cmd_to_sd),
		.cmd_to_sd_oe    (cmd_to_sd_oe)
	);

	initial begin
		clk_host = 1'b0;
		forever #HOST_HALF clk_host = ~clk_host;
	end

	initial begin
		clk_sd_card = 1'b0;
		forever #SD_HALF clk_sd_card = ~clk_sd_card;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [6:0] crc7_ref(input logic [39:0] data);
		logic [6:0] c;
		logic       fb;
		c = 7'd0;
		for (int i = 39; i >= 0; i--) begin
			fb = data[i] ^ c[6];
			c  = {c[5:0], 1'b0};
			if (fb)
				c = c ^ 7'h09;
		end
		return c;
	endfunction

	function automatic sd_bus_pkg::sd_token_t cmd_token_ref(input logic [5:0] idx,
			input logic [31:0] arg);
		return {2'b01, idx, arg, crc7_ref({2'b01, idx, arg}), 1'b1};
	endfunction

	function automatic sd_bus_pkg::sd_resp_t resp_token_ref(input logic [5:0] idx,
			input logic [31:0] status);
		sd_bus_pkg::sd_resp_t r;
		r.start_bit = 1'b0;
		r.tx_bit    = 1'b0;
		r.index     = idx;
		r.status    = status;
		r.crc       = crc7_ref({2'b00, idx, status});
		r.end_bit   = 1'b1;
		return r;
	endfunction

	function automatic sd_host_pkg::cmd_result_e expected_result(input resp_mode_e mode);
		case (mode)
			resp_good:    return sd_host_pkg::res_ok;
			resp_none:    return sd_host_pkg::res_timeout;
			resp_bad_crc: return sd_host_pkg::res_crc;
			default:      return sd_host_pkg::res_index;
		endcase
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic check_token(input sd_bus_pkg::sd_token_t expected,
			input sd_bus_pkg::sd_token_t actual);
		if (actual !== expected)
			fail_now($sformatf("error: test %s token expected %h actual %h",
				test_name, expected, actual));
	endtask

	task automatic check_status(input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
			fail_now($sformatf("error: test %s response_status expected %h actual %h",
				test_name, expected, actual));
	endtask

	task automatic check_result(input sd_host_pkg::cmd_result_e expected,
			input sd_host_pkg::cmd_result_e actual);
		if (actual !== expected)
			fail_now($sformatf("error: test %s result expected %s actual %s",
				test_name, expected.name(), actual.name()));
	endtask

	always @(dut0.assert0.fail_count) begin
		if (dut0.assert0.fail_count != 0)
			fail_now($sformatf("test %s: a concurrent assertion on sd_cmd failed",
				test_name));
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Host driver and card model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic issue_cmd(input logic [5:0] idx, input logic [31:0] arg);
		@(posedge clk_host);
		#DRIVE_DELAY;
		cmd_index = idx;
		cmd_arg   = arg;
		new_cmd   = 1'b1;
		@(posedge clk_host);
		#DRIVE_DELAY;
		new_cmd = 1'b0;
	endtask

	// Captures one command token and answers on falling SD edges.
	task automatic card_exchange(input resp_mode_e mode, input int delay,
			input sd_bus_pkg::sd_token_t resp, output sd_bus_pkg::sd_token_t token);
		int waited;
		int oe_cycles;
		waited    = 0;
		oe_cycles = 0;
		token     = '0;
		@(negedge clk_sd_card);
		while (cmd_to_sd_oe !== 1'b1) begin
			if (waited == OE_LIMIT)
				fail_now($sformatf("test %s: cmd_to_sd_oe never went high", test_name));
			waited++;
			@(negedge clk_sd_card);
		end
		while (cmd_to_sd_oe === 1'b1) begin
			if (oe_cycles == 56)
				fail_now($sformatf("test %s: cmd_to_sd_oe stayed high too long", test_name));
			token = {token[46:0], cmd_to_sd};
			oe_cycles++;
			@(negedge clk_sd_card);
		end
		if (oe_cycles != 48)
			fail_now($sformatf("test %s: cmd_to_sd_oe was high for %0d SD clocks, not 48",
				test_name, oe_cycles));
		if (mode != resp_none) begin
			repeat (delay) @(negedge clk_sd_card);
			for (int i = 47; i >= 0; i--) begin
				cmd_from_sd = resp[i];
				@(negedge clk_sd_card);
			end
			cmd_from_sd = 1'b1;
		end
	endtask

	task automatic wait_result(output sd_host_pkg::cmd_result_e res);
		int         cycles;
		logic       busy_prev;
		logic [3:0] flags;
		cycles    = 0;
		busy_prev = cmd_busy;
		@(negedge clk_host);
		flags = {cmd_complete, timeout_error, crc_error, index_error};
		while (flags == 4'b0000) begin
			if (cycles == FLAG_LIMIT)
				fail_now($sformatf("test %s: no completion flag was raised", test_name));
			cycles++;
			busy_prev = cmd_busy;
			@(negedge clk_host);
			flags = {cmd_complete, timeout_error, crc_error, index_error};
		end
		if (!$onehot(flags))
			fail_now($sformatf("test %s: several completion flags at once", test_name));
		if (busy_prev !== 1'b1 || cmd_busy !== 1'b0)
			fail_now($sformatf("test %s: cmd_busy did not fall with the flag", test_name));
		case (flags)
			4'b1000: res = sd_host_pkg::res_ok;
			4'b0100: res = sd_host_pkg::res_timeout;
			4'b0010: res = sd_host_pkg::res_crc;
			default: res = sd_host_pkg::res_index;
		endcase
		@(negedge clk_host);
		if ({cmd_complete, timeout_error, crc_error, index_error} != 4'b0000)
			fail_now($sformatf("test %s: completion flag longer than one cycle", test_name));
	endtask

	task automatic run_cmd(input string name, input resp_mode_e mode, input bit busy_poke);
		logic [31:0]                rnd;
		logic [5:0]                 idx;
		logic [31:0]                arg;
		logic [31:0]                status;
		int                         delay;
		sd_bus_pkg::sd_resp_t       resp;
		sd_bus_pkg::sd_token_t      token;
		sd_host_pkg::cmd_result_e   res;
		test_name = name;
		rnd       = $random(seed);
		idx       = rnd[5:0];
		delay     = int'(rnd[12:8]);
		arg       = $random(seed);
		status    = $random(seed);
		if (mode == resp_bad_index)
			resp = resp_token_ref(idx ^ 6'h15, status);
		else
			resp = resp_token_ref(idx, status);
		// One flipped CRC bit.
		if (mode == resp_bad_crc)
			resp.crc[rnd[18:16] % 7] = ~resp.crc[rnd[18:16] % 7];
		fork
			card_exchange(mode, delay, resp, token);
			begin
				issue_cmd(idx, arg);
				if (cmd_busy !== 1'b1)
					fail_now($sformatf("test %s: cmd_busy did not rise", test_name));
				if (busy_poke)
					issue_cmd(idx ^ 6'h2a, ~arg);
				wait_result(res);
			end
		join
		check_token(cmd_token_ref(idx, arg), token);
		check_result(expected_result(mode), res);
		if (mode != resp_none)
			last_status = status;
		check_status(last_status, response_status);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		rst_n       = 1'b0;
		new_cmd     = 1'b0;
		cmd_index   = 6'd0;
		cmd_arg     = 32'd0;
		cmd_from_sd = 1'b1;
		last_status = 32'd0;
		test_name   = "reset";
		repeat (3) @(posedge clk_host);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		repeat (2) @(posedge clk_host);
		check_status(32'd0, response_status);

		for (int i = 0; i < 4; i++)
			run_cmd("random_ok", resp_good, 1'b0);
		run_cmd("no_response", resp_none, 1'b0);
		run_cmd("bad_crc", resp_bad_crc, 1'b0);
		run_cmd("bad_index", resp_bad_index, 1'b0);
		run_cmd("busy_ignore", resp_good, 1'b1);
		run_cmd("after_ignore", resp_good, 1'b0);
		run_cmd("ok_after_timeout", resp_none, 1'b0);
		run_cmd("ok_final", resp_good, 1'b0);

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
